// ==== Makefile ====
# Verilator lint and simulation for the SHA-512/384 front end

VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := sha_acc_tb
FILELIST   := sha_acc.f
OBJ_DIR    := obj_dir
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/sha_acc_properties.sv ====
// SHA accelerator protocol checks
// Bound to the top level to watch the core command port and the bus hold

`timescale 1ns/100ps
`include "sha_acc_defines.svh"

module sha_acc_properties (
  input logic                   clk,
  input logic                   rst_b,
  input logic                   req_dv,
  input sha_acc_pkg::bus_req_t  req,
  input logic                   req_hold,
  input sha_acc_pkg::core_cmd_t core_cmd,
  input logic                   core_ready
);

  // Number of failed properties so far
  int   fail_count = 0;
  logic cmd_any;

  assign cmd_any = core_cmd.init | core_cmd.next;

  // ----------------------------------------
  // Core command port
  // ----------------------------------------
  cmd_onehot_a: assert property (@(posedge clk) disable iff (!rst_b)
    !(core_cmd.init && core_cmd.next))
    else begin
      $error("init and next high in the same cycle");
      fail_count++;
    end

  // The command was decided on the edge before it shows, so ready is checked there
  cmd_ready_a: assert property (@(posedge clk) disable iff (!rst_b)
    cmd_any |-> $past(core_ready))
    else begin
      $error("command issued while the core was not ready");
      fail_count++;
    end

  init_pulse_a: assert property (@(posedge clk) disable iff (!rst_b)
    core_cmd.init |=> !core_cmd.init)
    else begin
      $error("init held for more than one cycle");
      fail_count++;
    end

  next_pulse_a: assert property (@(posedge clk) disable iff (!rst_b)
    core_cmd.next |=> !core_cmd.next)
    else begin
      $error("next held for more than one cycle");
      fail_count++;
    end

  // ----------------------------------------
  // Bus hold
  // ----------------------------------------
  // Sending a block frees it, so hold is already down while that command is on the port
  hold_datain_a: assert property (@(posedge clk) disable iff (!rst_b)
    req_hold |-> (req_dv && req.write && (req.addr == `SHA_ACC_REG_DATAIN) && !cmd_any))
    else begin
      $error("req_hold raised outside a DATAIN write or while a command was issued");
      fail_count++;
    end

endmodule

// ==== bench/sha_acc_tb.sv ====
// SHA-512/384 front end testbench
// Streams LFSR messages over the register bus, models the hash core and
// checks every block against a reference SHA-2 padding model

`timescale 1ns/100ps
`include "sha_acc_defines.svh"

module sha_acc_tb;

  import sha_acc_pkg::*;

  localparam logic [31:0] SEED      = 32'h95df9d87;
  localparam int          MAX_BYTES = 640;

  logic          clk = 1'b0;
  logic          rst_b;
  logic          req_dv;
  bus_req_t      req;
  logic          req_hold;
  logic [31:0]   rdata;
  logic          err;
  core_cmd_t     core_cmd;
  sha_block_u    block;
  logic          core_ready;
  logic          core_digest_valid;

  logic [7:0]    msg [0:MAX_BYTES-1];
  logic [1023:0] exp_q [$];
  logic [31:0]   msg_lfsr = SEED;
  logic [31:0]   core_lfsr = SEED;
  logic          cur_mode;
  logic          hold_seen;
  int            cmd_seen;
  int            checks;
  int            errors;
  int            cycles;
  int            cycle_limit;
  int            lens [2:5];

  sha_acc_top dut_i (
    .clk               (clk),
    .rst_b             (rst_b),
    .req_dv            (req_dv),
    .req               (req),
    .req_hold          (req_hold),
    .rdata             (rdata),
    .err               (err),
    .core_cmd          (core_cmd),
    .block             (block),
    .core_ready        (core_ready),
    .core_digest_valid (core_digest_valid)
  );

  bind sha_acc_top sha_acc_properties props_i (
    .clk        (clk),
    .rst_b      (rst_b),
    .req_dv     (req_dv),
    .req        (req),
    .req_hold   (req_hold),
    .core_cmd   (core_cmd),
    .core_ready (core_ready)
  );

  always #4 clk = ~clk;

  // Run limit comes from the message lengths drawn at time zero
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Run stopped after %0d cycles with tests still running", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Random source and checks
  // ----------------------------------------
  // Galois LFSR for x^32 + x^22 + x^2 + x + 1 where the bit taken is the one shifted out
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_block(input string name, input logic [1023:0] got,
                             input logic [1023:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // ----------------------------------------
  // Bus access
  // ----------------------------------------
  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic bus_xfer(input logic [4:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rd, output logic er);
    req_dv = 1'b1;
    req.addr = addr;
    req.write = wr;
    req.wdata = wdata;
    #1;
    while (req_hold) begin
      hold_seen = 1'b1;
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    rd = rdata;
    er = err;
    req_dv = 1'b0;
  endtask

  task automatic read_check(input logic [4:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_xfer(addr, 1'b0, 32'd0, rd, er);
    check_word($sformatf("rdata @%02h", addr), rd, exp_data);
    check_word($sformatf("err @%02h", addr), 32'(er), 32'(exp_err));
  endtask

  // Writes always answer with zero read data
  task automatic write_check(input logic [4:0] addr, input logic [31:0] data,
                             input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_xfer(addr, 1'b1, data, rd, er);
    check_word($sformatf("rdata @%02h", addr), rd, 32'd0);
    check_word($sformatf("err @%02h", addr), 32'(er), 32'(exp_err));
  endtask

  // ----------------------------------------
  // Reference padding and core model
  // ----------------------------------------
  // Standard SHA-512 padding puts 0x80 after the data, then zeroes and the 128-bit bit length
  task automatic build_expected(input int len);
    int            nblk;
    int            g;
    logic [127:0]  len_bits;
    logic [1023:0] blk;
    logic [7:0]    v;
    nblk = (len + 17 + 127) / 128;
    len_bits = 128'(len) << 3;
    exp_q.delete();
    for (int b = 0; b < nblk; b++) begin
      for (int i = 0; i < 128; i++) begin
        g = b * 128 + i;
        if (g < len) v = msg[g];
        else if (g == len) v = 8'h80;
        else v = 8'h00;
        if (g >= nblk * 128 - 16) v = len_bits[8 * (nblk * 128 - 1 - g) +: 8];
        blk[1023 - 8 * i -: 8] = v;
      end
      exp_q.push_back(blk);
    end
  endtask

  // Busy for 1 to 8 cycles after each command and digest valid after the last one
  always begin : core_model
    logic [31:0] delay;
    @(negedge clk);
    if (rst_b && (core_cmd.init || core_cmd.next)) begin
      check_word("core_cmd.init", 32'(core_cmd.init), 32'(cmd_seen == 0));
      check_word("core_cmd.next", 32'(core_cmd.next), 32'(cmd_seen != 0));
      check_word("core_cmd.mode_512", 32'(core_cmd.mode_512), 32'(cur_mode));
      if (cmd_seen < exp_q.size()) begin
        check_block($sformatf("block %0d", cmd_seen), block, exp_q[cmd_seen]);
      end else begin
        $display("Command %0d arrived with no block left to send", cmd_seen);
        errors++;
      end
      cmd_seen++;
      core_ready = 1'b0;
      draw_bits(core_lfsr, 3, delay);
      repeat (delay + 1) @(negedge clk);
      core_ready = 1'b1;
      if (cmd_seen == exp_q.size()) begin
        core_digest_valid = 1'b1;
        @(negedge clk);
        core_digest_valid = 1'b0;
      end
    end
  end

  // One whole message from lock to release
  task automatic run_message(input int num, input string name, input int len,
                             input logic mode);
    logic [31:0] rd;
    logic        er;
    logic [31:0] r;
    int          err_start;
    err_start = errors;
    for (int i = 0; i < MAX_BYTES; i++) begin
      draw_bits(msg_lfsr, 8, r);
      msg[i] = r[7:0];
    end
    build_expected(len);
    cur_mode = mode;
    cmd_seen = 0;
    hold_seen = 1'b0;
    read_check(`SHA_ACC_REG_LOCK, 32'd0, 1'b0);
    write_check(`SHA_ACC_REG_MODE, 32'(mode), 1'b0);
    write_check(`SHA_ACC_REG_DLEN, 32'(len), 1'b0);
    // Bytes past DLEN in the last word are random and must be masked
    for (int k = 0; k < (len + 3) / 4; k++) begin
      write_check(`SHA_ACC_REG_DATAIN,
                  {msg[4 * k], msg[4 * k + 1], msg[4 * k + 2], msg[4 * k + 3]}, 1'b0);
    end
    write_check(`SHA_ACC_REG_EXECUTE, 32'd1, 1'b0);
    rd = '0;
    while (!rd[0]) begin
      bus_xfer(`SHA_ACC_REG_STATUS, 1'b0, 32'd0, rd, er);
    end
    check_word("STATUS", rd, 32'h3);
    check_word("command count", 32'(cmd_seen), 32'(exp_q.size()));
    if (num == 4) check_word("req_hold seen", 32'(hold_seen), 32'd1);
    write_check(`SHA_ACC_REG_LOCK, 32'd1, 1'b0);
    // Controller falls back to idle one cycle after the lock goes
    @(negedge clk);
    read_check(`SHA_ACC_REG_STATUS, 32'd0, 1'b0);
    $display("test %0d %s done with %0d errors", num, name, errors - err_start);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic        mode_2;
    int          err_start;
    rst_b = 1'b0;
    // A DATAIN write waits on the bus through reset
    req_dv = 1'b1;
    req.addr = `SHA_ACC_REG_DATAIN;
    req.write = 1'b1;
    req.wdata = 32'd0;
    core_ready = 1'b1;
    core_digest_valid = 1'b0;
    cur_mode = 1'b0;
    hold_seen = 1'b0;
    cmd_seen = 0;
    checks = 0;
    errors = 0;
    cycles = 0;
    // Lengths for the short, spill, three-block and block-aligned messages
    draw_bits(msg_lfsr, 5, r);
    draw_bits(msg_lfsr, 2, r2);
    lens[2] = 4 * int'(r % 27) + 1 + int'(r2 % 3);
    draw_bits(msg_lfsr, 1, r);
    mode_2 = r[0];
    draw_bits(msg_lfsr, 4, r);
    lens[3] = 112 + int'(r);
    draw_bits(msg_lfsr, 6, r);
    lens[4] = 276 + int'(r);
    draw_bits(msg_lfsr, 1, r);
    lens[5] = 128 * (2 + int'(r));
    cycle_limit = 400;
    for (int t = 2; t <= 5; t++) begin
      cycle_limit += 20 * ((lens[t] + 3) / 4) + 200 * ((lens[t] + 144) / 128);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    check_word("core_cmd", 32'(core_cmd), 32'd0);
    check_word("req_hold", 32'(req_hold), 32'd0);
    check_word("err", 32'(err), 32'd0);

    err_start = errors;
    read_check(`SHA_ACC_REG_LOCK, 32'd0, 1'b0);
    read_check(`SHA_ACC_REG_LOCK, 32'd1, 1'b0);
    write_check(`SHA_ACC_REG_LOCK, 32'd1, 1'b0);
    write_check(`SHA_ACC_REG_DATAIN, 32'hdeadbeef, 1'b1);
    read_check(`SHA_ACC_REG_STATUS, 32'd0, 1'b0);
    $display("test 1 lock done with %0d errors", errors - err_start);

    run_message(2, "short message", lens[2], mode_2);
    run_message(3, "length spill", lens[3], 1'b0);
    run_message(4, "multi block", lens[4], 1'b1);
    run_message(5, "block aligned", lens[5], 1'b1);

    err_start = errors;
    read_check(5'h1C, 32'd0, 1'b1);
    write_check(5'h18, 32'h12345678, 1'b1);
    $display("test 6 unknown address done with %0d errors", errors - err_start);

    $display("tests 6, checks %0d, errors %0d, property failures %0d",
             checks, errors, dut_i.props_i.fail_count);
    if (errors == 0 && dut_i.props_i.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== rtl/sha_acc_block_buf.sv ====
// SHA accelerator block buffer
// Packs DATAIN words big-endian into the 1024-bit block, tracks the
// write pointer and message byte count, and loads padded blocks

`timescale 1ns/100ps
`include "sha_acc_defines.svh"

module sha_acc_block_buf (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       datain_wr,
  input  logic [`SHA_ACC_DATA_W-1:0] wdata,
  input  logic                       ptr_clr,
  input  logic                       cnt_clr,
  input  sha_acc_pkg::pad_cmd_e      pad_cmd,
  input  logic [`SHA_ACC_DATA_W-1:0] dlen_bytes,
  output sha_acc_pkg::sha_block_u    block,
  output logic                       block_full,
  output logic                       bytes_pending
);

  import sha_acc_pkg::*;

  logic                       wr_pend;
  logic [`SHA_ACC_DATA_W-1:0] wdata_q;
  logic [5:0]                 wptr;
  logic [31:0]                bytes_wr;
  logic [31:0]                bytes_seen;
  logic                       slots_full;
  sha_block_u                 block_pad;

  // ----------------------------------------
  // Write staging
  // ----------------------------------------
  // An accepted word sits here for one cycle before it lands
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= datain_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (datain_wr) begin
      wdata_q <= wdata;
    end
  end

  assign bytes_pending = wr_pend;

  // Pointer and byte count advance as the word lands
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wptr     <= '0;
      bytes_wr <= '0;
    end else begin
      if (ptr_clr) begin
        wptr <= '0;
      end else if (wr_pend) begin
        wptr <= wptr + 6'd1;
      end
      if (cnt_clr) begin
        bytes_wr <= '0;
      end else if (wr_pend) begin
        bytes_wr <= bytes_wr + 32'd4;
      end
    end
  end

  // ----------------------------------------
  // Full detection
  // ----------------------------------------
  // Count the staged word too so a 33rd write is held in time
  assign slots_full = ((wptr + 6'(wr_pend)) == 6'(`SHA_ACC_BLOCK_WORDS));
  assign bytes_seen = bytes_wr + (wr_pend ? 32'd4 : 32'd0);

  // A last word that runs past DLEN is partial, so the block waits for padding
  assign block_full = slots_full & ~(bytes_seen > dlen_bytes);

  // ----------------------------------------
  // Block register
  // ----------------------------------------
  sha_acc_pad pad_i (
    .block_in   (block),
    .pad_cmd    (pad_cmd),
    .dlen_bytes (dlen_bytes),
    .block_out  (block_pad)
  );

  always_ff @(posedge clk) begin
    if (pad_cmd != pad_none) begin
      block <= block_pad;
    end else if (wr_pend) begin
      block.words[wptr[4:0]] <= wdata_q;
    end
  end

endmodule

// ==== rtl/sha_acc_ctrl.sv ====
// SHA accelerator block sequencer
// Decides when each block goes to the core, asks for padding at the end
// of the message and registers the init/next commands

`timescale 1ns/100ps
`include "sha_acc_defines.svh"

module sha_acc_ctrl (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       lock,
  input  logic                       execute,
  input  logic                       datain_wr,
  input  logic                       mode_512,
  input  logic [`SHA_ACC_DATA_W-1:0] dlen_bytes,
  input  logic                       block_full,
  input  logic                       bytes_pending,
  input  logic                       core_ready,
  input  logic                       core_digest_valid,
  output sha_acc_pkg::core_cmd_t     core_cmd,
  output logic                       ptr_clr,
  output logic                       cnt_clr,
  output sha_acc_pkg::pad_cmd_e      pad_cmd,
  output logic                       state_done
);

  import sha_acc_pkg::*;

  sha_state_e state_q;
  sha_state_e state_d;
  logic       core_rdy;
  logic       digest_vld;
  logic [6:0] tail_bytes;
  logic       extra_pad;
  logic       in_block;
  logic       arc_start;
  logic       arc_send;
  logic       arc_pad_0;
  logic       arc_pad_1;
  logic       arc_done;

  // The core only drops ready a cycle after it sees a command
  assign core_rdy   = core_ready & ~(core_cmd.init | core_cmd.next);
  assign digest_vld = core_digest_valid & ~(core_cmd.init | core_cmd.next);

  // Data bytes in the final block and whether the length still fits there
  assign tail_bytes = dlen_bytes[6:0];
  assign extra_pad  = (tail_bytes >= 7'(`SHA_ACC_PAD_LIMIT));

  // ----------------------------------------
  // Transition conditions
  // ----------------------------------------
  assign in_block  = lock & ((state_q == sha_block_0) | (state_q == sha_block_n));
  assign arc_start = lock & (state_q == sha_idle) & datain_wr;
  // A full block wins over padding so a block-aligned message is sent before the pad block
  assign arc_send  = in_block & block_full & ~bytes_pending & core_rdy;
  assign arc_pad_0 = in_block & ~arc_send & execute & ~bytes_pending & core_rdy;
  assign arc_pad_1 = lock & (state_q == sha_pad_0) & extra_pad & core_rdy;
  assign arc_done  = lock & digest_vld &
                     (((state_q == sha_pad_0) & ~extra_pad) | (state_q == sha_pad_1));

  always_comb begin
    state_d = state_q;
    if (!lock) begin
      state_d = sha_idle;
    end else begin
      case (state_q)
        sha_idle: begin
          if (arc_start) state_d = sha_block_0;
        end
        sha_block_0, sha_block_n: begin
          if (arc_send) state_d = sha_block_n;
          else if (arc_pad_0) state_d = sha_pad_0;
        end
        sha_pad_0: begin
          if (arc_pad_1) state_d = sha_pad_1;
          else if (arc_done) state_d = sha_done;
        end
        sha_pad_1: begin
          if (arc_done) state_d = sha_done;
        end
        sha_done: state_d = sha_done;
        default: state_d = sha_idle;
      endcase
    end
  end

  // ----------------------------------------
  // State and command registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q  <= sha_idle;
      core_cmd <= '0;
    end else begin
      state_q <= state_d;
      // Whatever leaves block_0 is the first block of the message
      core_cmd.init     <= (state_q == sha_block_0) & (arc_send | arc_pad_0);
      core_cmd.next     <= ((state_q == sha_block_n) & (arc_send | arc_pad_0)) | arc_pad_1;
      core_cmd.mode_512 <= mode_512;
    end
  end

  // Padding lands in the block on the same edge as the transition
  assign pad_cmd = arc_pad_0 ? pad_data_end :
                   arc_pad_1 ? pad_length_only : pad_none;

  assign ptr_clr    = arc_send | ~lock;
  assign cnt_clr    = ~lock;
  assign state_done = (state_q == sha_done);

endmodule

// ==== rtl/sha_acc_defines.svh ====
// SHA-512/384 accelerator front end shared constants
// Bus width, block geometry, padding threshold and register map

`ifndef SHA_ACC_DEFINES_SVH
`define SHA_ACC_DEFINES_SVH

// Bus data width in bits
`define SHA_ACC_DATA_W 32

// One SHA-512 message block
`define SHA_ACC_BLOCK_W 1024
`define SHA_ACC_BLOCK_WORDS 32
`define SHA_ACC_BLOCK_BYTES 128

// Tail byte count at and above which the 128-bit length spills into a second block
`define SHA_ACC_PAD_LIMIT 112

// Register map, byte offsets
`define SHA_ACC_ADDR_W 5
`define SHA_ACC_REG_LOCK 5'h00
`define SHA_ACC_REG_MODE 5'h04
`define SHA_ACC_REG_DLEN 5'h08
`define SHA_ACC_REG_DATAIN 5'h0C
`define SHA_ACC_REG_EXECUTE 5'h10
`define SHA_ACC_REG_STATUS 5'h14

`endif

// ==== rtl/sha_acc_pad.sv ====
// SHA-2 message padding for the final block or blocks
// Masks the tail, appends the 0x80 marker and places the bit length

`timescale 1ns/100ps
`include "sha_acc_defines.svh"

module sha_acc_pad (
  input  sha_acc_pkg::sha_block_u    block_in,
  input  sha_acc_pkg::pad_cmd_e      pad_cmd,
  input  logic [`SHA_ACC_DATA_W-1:0] dlen_bytes,
  output sha_acc_pkg::sha_block_u    block_out
);

  import sha_acc_pkg::*;

  logic [6:0]   tail_bytes;
  logic         extra_pad;
  logic [127:0] len_bits;

  // Bytes of real data in the last block
  assign tail_bytes = dlen_bytes[6:0];
  assign extra_pad  = (tail_bytes >= 7'(`SHA_ACC_PAD_LIMIT));

  // Message length in bits, big-endian in the top 16 bytes
  assign len_bits = {93'd0, dlen_bytes, 3'b000};

  always_comb begin
    block_out = block_in;
    case (pad_cmd)
      pad_data_end: begin
        // Keep the data, clear everything after it
        for (int i = 0; i < `SHA_ACC_BLOCK_BYTES; i++) begin
          if (i >= int'(tail_bytes)) block_out.bytes[i] = 8'h00;
        end
        block_out.bytes[tail_bytes] = 8'h80;
        // The length only goes here when the marker left room for it
        if (!extra_pad) begin
          block_out.bytes[`SHA_ACC_PAD_LIMIT:`SHA_ACC_BLOCK_BYTES-1] = len_bits;
        end
      end
      pad_length_only: begin
        // Spill block holding nothing but the length
        block_out = '0;
        block_out.bytes[`SHA_ACC_PAD_LIMIT:`SHA_ACC_BLOCK_BYTES-1] = len_bits;
      end
      default: block_out = block_in;
    endcase
  end

endmodule

// ==== rtl/sha_acc_pkg.sv ====
// SHA-512/384 accelerator front end types
// Bus request, core command, block views and FSM encodings

`include "sha_acc_defines.svh"

package sha_acc_pkg;

  // One bus request as seen by the register file
  typedef struct packed {
    logic [`SHA_ACC_ADDR_W-1:0] addr;
    logic                       write;
    logic [`SHA_ACC_DATA_W-1:0] wdata;
  } bus_req_t;

  // Command port of the hash core
  typedef struct packed {
    logic init;
    logic next;
    logic mode_512;
  } core_cmd_t;

  // The block register seen as words (data writes) or bytes (padding)
  // Index 0 is the most significant part in both views
  typedef union packed {
    logic [0:`SHA_ACC_BLOCK_WORDS-1][`SHA_ACC_DATA_W-1:0] words;
    logic [0:`SHA_ACC_BLOCK_BYTES-1][7:0]                 bytes;
  } sha_block_u;

  // Padding request from the controller to the block buffer
  typedef enum logic [1:0] {
    pad_none,
    pad_data_end,
    pad_length_only
  } pad_cmd_e;

  // Block sequencing states
  typedef enum logic [2:0] {
    sha_idle,
    sha_block_0,
    sha_block_n,
    sha_pad_0,
    sha_pad_1,
    sha_done
  } sha_state_e;

endpackage

// ==== rtl/sha_acc_regs.sv ====
// SHA accelerator register file
// Decodes the register map, owns LOCK, MODE, DLEN and EXECUTE,
// returns registered read data and errors, and stalls DATAIN on a full block

`timescale 1ns/100ps
`include "sha_acc_defines.svh"

module sha_acc_regs (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       req_dv,
  input  sha_acc_pkg::bus_req_t      req,
  input  logic                       block_full,
  input  logic                       state_done,
  output logic                       req_hold,
  output logic [`SHA_ACC_DATA_W-1:0] rdata,
  output logic                       err,
  output logic                       lock,
  output logic                       execute,
  output logic                       datain_wr,
  output logic                       mode_512,
  output logic [`SHA_ACC_DATA_W-1:0] dlen_bytes
);

  logic                       accept;
  logic                       hit_lock;
  logic                       hit_mode;
  logic                       hit_dlen;
  logic                       hit_datain;
  logic                       hit_execute;
  logic                       hit_status;
  logic                       hit_any;
  logic                       wr_ok;
  logic                       wr_denied;
  logic [`SHA_ACC_DATA_W-1:0] rd_val;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign hit_lock    = (req.addr == `SHA_ACC_REG_LOCK);
  assign hit_mode    = (req.addr == `SHA_ACC_REG_MODE);
  assign hit_dlen    = (req.addr == `SHA_ACC_REG_DLEN);
  assign hit_datain  = (req.addr == `SHA_ACC_REG_DATAIN);
  assign hit_execute = (req.addr == `SHA_ACC_REG_EXECUTE);
  assign hit_status  = (req.addr == `SHA_ACC_REG_STATUS);
  assign hit_any     = hit_lock | hit_mode | hit_dlen | hit_datain | hit_execute | hit_status;

  // Only a legal DATAIN write is stalled, and only while the block is waiting on the core
  assign req_hold = req_dv & req.write & hit_datain & lock & block_full;
  assign accept   = req_dv & ~req_hold;

  // Writes to the message registers need the lock
  assign wr_ok     = accept & req.write & lock;
  assign wr_denied = req.write & ~lock & (hit_mode | hit_dlen | hit_datain | hit_execute);
  assign datain_wr = wr_ok & hit_datain;

  // ----------------------------------------
  // Control registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      lock       <= 1'b0;
      mode_512   <= 1'b0;
      dlen_bytes <= '0;
      execute    <= 1'b0;
    end else begin
      // Reading LOCK grabs it, writing a 1 gives it back
      if (accept & hit_lock) begin
        lock <= req.write ? (lock & ~req.wdata[0]) : 1'b1;
      end
      if (wr_ok & hit_mode) begin
        mode_512 <= req.wdata[0];
      end
      if (wr_ok & hit_dlen) begin
        dlen_bytes <= req.wdata;
      end
      // EXECUTE stays up until the lock goes away
      if (!lock) begin
        execute <= 1'b0;
      end else if (wr_ok & hit_execute) begin
        execute <= 1'b1;
      end
    end
  end

  // Read mux, DATAIN and unknown offsets read as zero
  always_comb begin
    rd_val = '0;
    case (req.addr)
      `SHA_ACC_REG_LOCK:    rd_val[0] = lock;
      `SHA_ACC_REG_MODE:    rd_val[0] = mode_512;
      `SHA_ACC_REG_DLEN:    rd_val = dlen_bytes;
      `SHA_ACC_REG_EXECUTE: rd_val[0] = execute;
      `SHA_ACC_REG_STATUS:  rd_val[1:0] = {lock, state_done};
      default:              rd_val = '0;
    endcase
  end

  // Response arrives the cycle after acceptance
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rdata <= '0;
      err   <= 1'b0;
    end else begin
      rdata <= (accept & ~req.write) ? rd_val : '0;
      err   <= accept & (~hit_any | wr_denied);
    end
  end

endmodule

// ==== rtl/sha_acc_top.sv ====
// SHA-512/384 accelerator message front end
// Register file, block sequencer and block buffer in front of an external hash core

`timescale 1ns/100ps
`include "sha_acc_defines.svh"

module sha_acc_top (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       req_dv,
  input  sha_acc_pkg::bus_req_t      req,
  output logic                       req_hold,
  output logic [`SHA_ACC_DATA_W-1:0] rdata,
  output logic                       err,
  output sha_acc_pkg::core_cmd_t     core_cmd,
  output sha_acc_pkg::sha_block_u    block,
  input  logic                       core_ready,
  input  logic                       core_digest_valid
);

  import sha_acc_pkg::*;

  logic                       lock;
  logic                       execute;
  logic                       datain_wr;
  logic                       mode_512;
  logic [`SHA_ACC_DATA_W-1:0] dlen_bytes;
  logic                       block_full;
  logic                       bytes_pending;
  logic                       ptr_clr;
  logic                       cnt_clr;
  logic                       state_done;
  pad_cmd_e                   pad_cmd;

  // ----------------------------------------
  // Bus side
  // ----------------------------------------
  sha_acc_regs regs_i (
    .clk        (clk),
    .rst_b      (rst_b),
    .req_dv     (req_dv),
    .req        (req),
    .block_full (block_full),
    .state_done (state_done),
    .req_hold   (req_hold),
    .rdata      (rdata),
    .err        (err),
    .lock       (lock),
    .execute    (execute),
    .datain_wr  (datain_wr),
    .mode_512   (mode_512),
    .dlen_bytes (dlen_bytes)
  );

  // ----------------------------------------
  // Sequencing and block storage
  // ----------------------------------------
  sha_acc_ctrl ctrl_i (
    .clk               (clk),
    .rst_b             (rst_b),
    .lock              (lock),
    .execute           (execute),
    .datain_wr         (datain_wr),
    .mode_512          (mode_512),
    .dlen_bytes        (dlen_bytes),
    .block_full        (block_full),
    .bytes_pending     (bytes_pending),
    .core_ready        (core_ready),
    .core_digest_valid (core_digest_valid),
    .core_cmd          (core_cmd),
    .ptr_clr           (ptr_clr),
    .cnt_clr           (cnt_clr),
    .pad_cmd           (pad_cmd),
    .state_done        (state_done)
  );

  // Write data comes straight off the bus request
  sha_acc_block_buf block_buf_i (
    .clk           (clk),
    .rst_b         (rst_b),
    .datain_wr     (datain_wr),
    .wdata         (req.wdata),
    .ptr_clr       (ptr_clr),
    .cnt_clr       (cnt_clr),
    .pad_cmd       (pad_cmd),
    .dlen_bytes    (dlen_bytes),
    .block         (block),
    .block_full    (block_full),
    .bytes_pending (bytes_pending)
  );

endmodule

// ==== sha_acc.f ====
+incdir+rtl
rtl/sha_acc_pkg.sv
rtl/sha_acc_regs.sv
rtl/sha_acc_ctrl.sv
rtl/sha_acc_pad.sv
rtl/sha_acc_block_buf.sv
rtl/sha_acc_top.sv
bench/sha_acc_properties.sv
bench/sha_acc_tb.sv
